// File: vls_addrgen.f
design/vls_pkg.sv
design/vls_fifo.sv
design/vls_op_decode.sv
design/vls_burst_gen.sv
design/vls_addrgen_top.sv
verif/tb_clock.sv
verif/vls_addrgen_tb.sv

// File: Makefile
TOP   := vls_addrgen_tb
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vls_addrgen.f \
		--top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf $(BUILD) sim.log

// File: verif/vls_addrgen_tb.sv
// Testbench for the vector load/store address generator
// Random operations and ready patterns, a reference model that expands
// each accepted operation, and monitors on the AX handshakes and queue pops
module vls_addrgen_tb;

  localparam int unsigned NumOps        = 200;
  localparam int unsigned ClkPeriod     = 40;
  localparam longint unsigned TimeoutCycles = longint'(NumOps) * 64 * 8;

  typedef struct packed {
    logic             is_load;
    logic             last;
    vls_pkg::vls_ax_t ax;
  } exp_req_t;

  typedef struct packed {
    logic               burst;
    vls_pkg::vls_addr_t entry;
  } exp_entry_t;

  logic               clk_i;
  logic               rst_ni;
  vls_pkg::vls_op_t   op_i;
  logic               op_valid_i;
  logic               op_ready_o;
  vls_pkg::vls_ax_t   ar_o;
  logic               ar_valid_o;
  logic               ar_ready_i;
  vls_pkg::vls_ax_t   aw_o;
  logic               aw_valid_o;
  logic               aw_ready_i;
  vls_pkg::vls_addr_t addr_o;
  logic               addr_valid_o;
  logic               addr_ready_i;
  logic               done_o;

  integer     seed;
  int         ops_accepted;
  int         done_count;
  exp_req_t   exp_req[$];
  exp_entry_t exp_entry[$];

  tb_clock #(.Period(ClkPeriod)) i_clock (.clk_o(clk_i));

  vls_addrgen_top uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .op_i         (op_i),
    .op_valid_i   (op_valid_i),
    .op_ready_o   (op_ready_o),
    .ar_o         (ar_o),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .aw_o         (aw_o),
    .aw_valid_o   (aw_valid_o),
    .aw_ready_i   (aw_ready_i),
    .addr_o       (addr_o),
    .addr_valid_o (addr_valid_o),
    .addr_ready_i (addr_ready_i),
    .done_o       (done_o)
  );

  task automatic report_value(input string test, input logic [127:0] exp_v,
                              input logic [127:0] act_v);
    $display("[ERROR] %s: expected %0h, actual %0h", test, exp_v, act_v);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_text(input string msg);
    $display("Check failed: %s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Base sits in the last quarter of a page so bursts often straddle it
  function automatic vls_pkg::vls_op_t random_op();
    vls_pkg::vls_op_t op;
    op.is_load = (rand_below(2) == 0);
    op.strided = (rand_below(2) == 0);
    op.rs1     = 64'h8000_0000 + 64'(rand_below(16)) * 64'(vls_pkg::PageBytes) +
                 64'(192 + rand_below(64));
    op.rs2     = longint'(int'(rand_below(65)) - 32);
    op.imm     = 16'(int'(rand_below(16)) - 8);
    op.ew      = 2'(rand_below(4));
    op.vl      = 16'(1 + rand_below(64));
    return op;
  endfunction

  task automatic drive_readies();
    ar_ready_i   = (rand_below(10) < 7);
    aw_ready_i   = (rand_below(10) < 7);
    addr_ready_i = (rand_below(10) < 7);
  endtask

  task automatic add_request(input logic is_load, input logic burst,
                             input longint unsigned addr, input longint unsigned len,
                             input logic last);
    longint unsigned bus;
    exp_req_t        req;
    exp_entry_t      ent;
    bus          = longint'(vls_pkg::BusBytes);
    req.is_load  = is_load;
    req.last     = last;
    req.ax.addr  = addr & ~(bus - 1);
    // Beats needed once the unaligned head bytes are counted
    req.ax.len   = 8'(((len + (addr % bus) + bus - 1) / bus) - 1);
    req.ax.size  = 3'(vls_pkg::BusSizeLog);
    exp_req.push_back(req);
    ent.burst           = burst;
    ent.entry.addr      = addr;
    ent.entry.len_bytes = 9'(len);
    ent.entry.is_load   = is_load;
    exp_entry.push_back(ent);
  endtask

  // Reference expansion of one accepted operation
  task automatic expand_op(input vls_pkg::vls_op_t op);
    longint unsigned eb;
    longint unsigned addr;
    longint unsigned rem;
    longint unsigned room;
    longint unsigned len;
    longint unsigned page;
    eb   = 64'd1 << op.ew;
    page = longint'(vls_pkg::PageBytes);
    addr = op.rs1 + longint'($signed(op.imm)) * eb;
    if (!op.strided) begin
      rem = longint'(op.vl) * eb;
      while (rem != 0) begin
        room = page - (addr % page);
        len  = (rem < room) ? rem : room;
        add_request(op.is_load, 1'b1, addr, len, rem == len);
        addr += len;
        rem  -= len;
      end
    end else begin
      for (int i = 0; i < int'(op.vl); i++) begin
        add_request(op.is_load, 1'b0, addr + longint'(i) * op.rs2, eb,
                    i == int'(op.vl) - 1);
      end
    end
  endtask

  task automatic check_idle();
    assert (!ar_valid_o && !aw_valid_o && !addr_valid_o && !done_o)
      else report_text("a valid or done output was high during or just after reset");
  endtask

  // Nothing outstanding means the decode register is empty
  task automatic check_op_ready();
    if (exp_req.size() == 0) begin
      assert (op_ready_o)
        else report_text("op_ready_o was low while no operation was in flight");
    end
  endtask

  task automatic check_ax_handshake();
    exp_req_t         req;
    vls_pkg::vls_ax_t act;
    logic             ar_fire;
    logic             aw_fire;
    ar_fire = ar_valid_o && ar_ready_i;
    aw_fire = aw_valid_o && aw_ready_i;
    if (done_o) begin
      done_count++;
    end
    if (!ar_fire && !aw_fire) begin
      assert (!done_o)
        else report_text("done_o pulsed on a cycle without an AR or AW handshake");
    end else begin
      assert (exp_req.size() != 0)
        else report_text("an AR or AW request was accepted with none expected");
      req = exp_req.pop_front();
      act = ar_fire ? ar_o : aw_o;
      assert (ar_fire == req.is_load)
        else report_value("direction", 128'(req.is_load), 128'(ar_fire));
      assert (act == req.ax)
        else report_value("ax_request", 128'(req.ax), 128'(act));
      assert (done_o == req.last)
        else report_value("done_pulse", 128'(req.last), 128'(done_o));
    end
  endtask

  task automatic check_queue_pop();
    exp_entry_t ent;
    int         page_end;
    if (addr_valid_o && addr_ready_i) begin
      assert (exp_entry.size() != 0)
        else report_text("an address queue entry was popped with none expected");
      ent      = exp_entry.pop_front();
      page_end = int'(addr_o.addr[vls_pkg::PageOffW-1:0]) + int'(addr_o.len_bytes);
      assert (!ent.burst || page_end <= int'(vls_pkg::PageBytes))
        else report_value("page_bound", 128'(vls_pkg::PageBytes), 128'(page_end));
      assert (addr_o == ent.entry)
        else report_value("queue_entry", 128'(ent.entry), 128'(addr_o));
    end
  endtask

  // Monitors, sampled on the rising edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      check_op_ready();
      check_ax_handshake();
      check_queue_pop();
      if (op_valid_i && op_ready_o) begin
        expand_op(op_i);
        ops_accepted++;
      end
    end
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("RESULT: FAIL");
    $fatal(1);
  end

  initial begin
    vls_pkg::vls_op_t op;
    seed         = 32'h7183;
    ops_accepted = 0;
    done_count   = 0;
    rst_ni       = 1'b0;
    op_i         = '0;
    op_valid_i   = 1'b0;
    ar_ready_i   = 1'b0;
    aw_ready_i   = 1'b0;
    addr_ready_i = 1'b0;

    repeat (4) begin
      @(negedge clk_i);
      check_idle();
    end
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_idle();

    for (int n = 0; n < int'(NumOps); n++) begin
      // Occasional idle cycle between operations
      if (rand_below(4) == 0) begin
        @(negedge clk_i);
        drive_readies();
        op_valid_i = 1'b0;
      end
      op = random_op();
      @(negedge clk_i);
      drive_readies();
      op_i       = op;
      op_valid_i = 1'b1;
      @(posedge clk_i);
      while (!op_ready_o) begin
        @(negedge clk_i);
        drive_readies();
        @(posedge clk_i);
      end
    end

    @(negedge clk_i);
    op_valid_i = 1'b0;
    drive_readies();
    while (exp_req.size() != 0 || exp_entry.size() != 0) begin
      @(negedge clk_i);
      drive_readies();
    end

    assert (!ar_valid_o && !aw_valid_o && !addr_valid_o && !done_o)
      else report_text("a valid or done output stayed high after the last expected request");
    assert (done_count == ops_accepted) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      report_value("done_count", 128'(ops_accepted), 128'(done_count));
    end
  end

endmodule

// File: verif/tb_clock.sv
// Testbench clock source
// Free-running clock, starts low, period of 40 time units
module tb_clock #(
  parameter int unsigned Period = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(Period / 2) clk_o = ~clk_o;
    end
  end

endmodule

// File: design/vls_addrgen_top.sv
// Vector load/store address generator, top level
// Decode stage, burst generator and the address queue for the datapath
module vls_addrgen_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vls_pkg::vls_op_t    op_i,
  input  logic                op_valid_i,
  output logic                op_ready_o,
  output vls_pkg::vls_ax_t    ar_o,
  output logic                ar_valid_o,
  input  logic                ar_ready_i,
  output vls_pkg::vls_ax_t    aw_o,
  output logic                aw_valid_o,
  input  logic                aw_ready_i,
  output vls_pkg::vls_addr_t  addr_o,
  output logic                addr_valid_o,
  input  logic                addr_ready_i,
  output logic                done_o
);

  vls_pkg::vls_desc_t desc;
  logic               desc_valid;
  logic               desc_ready;
  vls_pkg::vls_addr_t q_entry;
  logic               q_push;
  logic               q_full;
  logic               q_empty;

  vls_op_decode i_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .op_i         (op_i),
    .op_valid_i   (op_valid_i),
    .op_ready_o   (op_ready_o),
    .desc_o       (desc),
    .desc_valid_o (desc_valid),
    .desc_ready_i (desc_ready)
  );

  vls_burst_gen i_burst_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .desc_i       (desc),
    .desc_valid_i (desc_valid),
    .desc_ready_o (desc_ready),
    .q_full_i     (q_full),
    .ar_o         (ar_o),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .aw_o         (aw_o),
    .aw_valid_o   (aw_valid_o),
    .aw_ready_i   (aw_ready_i),
    .q_entry_o    (q_entry),
    .q_push_o     (q_push),
    .done_o       (done_o)
  );

  // Address queue drained by the load/store datapath
  vls_fifo #(
    .dtype (vls_pkg::vls_addr_t),
    .Depth (vls_pkg::AddrQDepth)
  ) i_addr_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (q_entry),
    .push_i  (q_push),
    .full_o  (q_full),
    .data_o  (addr_o),
    .empty_o (q_empty),
    .pop_i   (addr_ready_i && !q_empty)
  );

  assign addr_valid_o = !q_empty;

endmodule

// File: design/vls_burst_gen.sv
// Burst generator for vector memory operations
// Walks one descriptor and issues page-bounded bursts (unit stride) or
// one request per element (strided) on AR or AW, mirrored into the queue
module vls_burst_gen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vls_pkg::vls_desc_t  desc_i,
  input  logic                desc_valid_i,
  output logic                desc_ready_o,
  input  logic                q_full_i,
  output vls_pkg::vls_ax_t    ar_o,
  output logic                ar_valid_o,
  input  logic                ar_ready_i,
  output vls_pkg::vls_ax_t    aw_o,
  output logic                aw_valid_o,
  input  logic                aw_ready_i,
  output vls_pkg::vls_addr_t  q_entry_o,
  output logic                q_push_o,
  output logic                done_o
);

  typedef enum logic {
    IDLE,
    GEN
  } state_e;

  typedef logic [vls_pkg::LenBytesW:0] span_t;

  state_e               state_q;
  state_e               state_d;
  vls_pkg::vls_desc_t   cur_q;
  vls_pkg::vls_desc_t   cur_d;
  vls_pkg::len_bytes_t  page_room;
  vls_pkg::len_bytes_t  req_len;
  span_t                span;
  span_t                beats;
  vls_pkg::vls_ax_t     ax_req;
  logic                 ax_valid;
  logic                 ax_ready;
  logic                 fire;
  logic                 last;

  // Bytes left before the next page boundary, 1 to PageBytes
  assign page_room = vls_pkg::PageBytes[vls_pkg::LenBytesW-1:0] -
                     {1'b0, cur_q.addr[vls_pkg::PageOffW-1:0]};

  always_comb begin
    if (!cur_q.burst) begin
      req_len = vls_pkg::len_bytes_t'(cur_q.elem_bytes);
    end else if (cur_q.rem_bytes < vls_pkg::rem_t'(page_room)) begin
      req_len = vls_pkg::len_bytes_t'(cur_q.rem_bytes);
    end else begin
      req_len = page_room;
    end
  end

  // Beats covered once the unaligned head is included
  assign span  = span_t'(req_len) + span_t'(cur_q.addr[vls_pkg::BusSizeLog-1:0]) +
                 span_t'(vls_pkg::BusBytes - 1);
  assign beats = span >> vls_pkg::BusSizeLog;

  assign ax_req.addr = cur_q.addr & ~vls_pkg::addr_t'(vls_pkg::BusBytes - 1);
  assign ax_req.len  = 8'(beats - 1'b1);
  assign ax_req.size = vls_pkg::BusSizeLog[2:0];

  assign ar_o = ax_req;
  assign aw_o = ax_req;

  // No request while the queue has no room for its entry
  assign ax_valid   = (state_q == GEN) && !q_full_i;
  assign ar_valid_o = ax_valid && cur_q.is_load;
  assign aw_valid_o = ax_valid && !cur_q.is_load;
  assign ax_ready   = cur_q.is_load ? ar_ready_i : aw_ready_i;
  assign fire       = ax_valid && ax_ready;
  assign last       = fire && (cur_q.rem_bytes == vls_pkg::rem_t'(req_len));

  assign q_entry_o.addr      = cur_q.addr;
  assign q_entry_o.len_bytes = req_len;
  assign q_entry_o.is_load   = cur_q.is_load;
  assign q_push_o            = fire;
  assign done_o              = last;

  // Next descriptor may load on the cycle the last request goes out
  assign desc_ready_o = (state_q == IDLE) || last;

  always_comb begin
    state_d = state_q;
    cur_d   = cur_q;
    if (fire) begin
      cur_d.rem_bytes = cur_q.rem_bytes - vls_pkg::rem_t'(req_len);
      if (cur_q.burst) begin
        cur_d.addr = cur_q.addr + vls_pkg::addr_t'(req_len);
      end else begin
        cur_d.addr = cur_q.addr + cur_q.stride;
      end
    end
    if (desc_ready_o && desc_valid_i) begin
      cur_d   = desc_i;
      state_d = GEN;
    end else if (last) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    cur_q <= cur_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // A raised request holds until it is taken
  a_ax_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ax_valid && !ax_ready |=> ax_valid && $stable(ax_req) && $stable(cur_q.is_load));

endmodule

// File: design/vls_op_decode.sv
// Operation decode for the address generator
// Computes start address, stride and byte count of one vector memory
// operation and holds it in a single descriptor register
module vls_op_decode (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vls_pkg::vls_op_t    op_i,
  input  logic                op_valid_i,
  output logic                op_ready_o,
  output vls_pkg::vls_desc_t  desc_o,
  output logic                desc_valid_o,
  input  logic                desc_ready_i
);

  vls_pkg::vls_desc_t desc_d;
  vls_pkg::vls_desc_t desc_q;
  logic               desc_valid_q;
  logic               accept;
  vls_pkg::addr_t     imm_ext;
  vls_pkg::addr_t     imm_scaled;
  logic [3:0]         elem_bytes;

  // Free when empty or draining this cycle
  assign op_ready_o = !desc_valid_q || desc_ready_i;
  assign accept     = op_valid_i && op_ready_o;

  // Immediate counts elements, sign extend then scale
  assign imm_ext = {{(vls_pkg::AddrWidth - vls_pkg::ImmWidth){op_i.imm[vls_pkg::ImmWidth-1]}},
                    op_i.imm};
  assign imm_scaled = imm_ext << op_i.ew;
  assign elem_bytes = 4'b0001 << op_i.ew;

  always_comb begin
    desc_d.addr       = op_i.rs1 + imm_scaled;
    desc_d.elem_bytes = elem_bytes;
    desc_d.rem_bytes  = vls_pkg::rem_t'(op_i.vl) << op_i.ew;
    desc_d.is_load    = op_i.is_load;
    desc_d.burst      = !op_i.strided;
    if (op_i.strided) begin
      desc_d.stride = op_i.rs2;
    end else begin
      desc_d.stride = vls_pkg::addr_t'(elem_bytes);
    end
  end

  // Descriptor payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      desc_q <= desc_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_valid_q <= 1'b0;
    end else if (accept) begin
      desc_valid_q <= 1'b1;
    end else if (desc_ready_i) begin
      desc_valid_q <= 1'b0;
    end
  end

  assign desc_o       = desc_q;
  assign desc_valid_o = desc_valid_q;

  a_vl_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (op_i.vl != '0));

endmodule

// File: design/vls_fifo.sv
// Synchronous FIFO with a typed payload
// Circular buffer with read/write pointers and an occupancy count
module vls_fifo #(
  parameter type         dtype = logic,
  parameter int unsigned Depth = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  dtype data_i,
  input  logic push_i,
  output logic full_o,
  output dtype data_o,
  output logic empty_o,
  input  logic pop_i
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  dtype mem_q [Depth];
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t cnt_q;
  logic do_push;
  logic do_pop;

  assign full_o  = (cnt_q == cnt_t'(Depth));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Storage, written only on a push
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      cnt_q <= cnt_q + cnt_t'(do_push) - cnt_t'(do_pop);
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o |-> !push_i);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    empty_o |-> !pop_i);

endmodule

// File: design/vls_pkg.sv
// Vector load/store address generator
// Shared widths, bus geometry and the structs passed between the blocks
package vls_pkg;

  // Memory and AXI bus geometry
  localparam int unsigned AddrWidth  = 64;
  localparam int unsigned BusBytes   = 8;
  localparam int unsigned BusSizeLog = $clog2(BusBytes);
  localparam int unsigned PageBytes  = 256;
  localparam int unsigned PageOffW   = $clog2(PageBytes);

  // Operation fields and derived counters
  localparam int unsigned VlWidth    = 16;
  localparam int unsigned ImmWidth   = 16;
  localparam int unsigned RemWidth   = VlWidth + 3;
  localparam int unsigned LenBytesW  = PageOffW + 1;

  // Address queue towards the load/store datapath
  localparam int unsigned AddrQDepth = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [RemWidth-1:0]  rem_t;
  typedef logic [LenBytesW-1:0] len_bytes_t;

  // One vector memory operation from the sequencer
  typedef struct packed {
    logic                       is_load;
    logic                       strided;
    addr_t                      rs1;
    logic signed [AddrWidth-1:0] rs2;
    logic signed [ImmWidth-1:0] imm;
    logic [1:0]                 ew;
    logic [VlWidth-1:0]         vl;
  } vls_op_t;

  // Decoded operation, walked by the burst generator
  typedef struct packed {
    addr_t      addr;
    addr_t      stride;
    rem_t       rem_bytes;
    logic [3:0] elem_bytes;
    logic       is_load;
    logic       burst;
  } vls_desc_t;

  // AR/AW request
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
  } vls_ax_t;

  // Address queue entry, byte exact
  typedef struct packed {
    addr_t      addr;
    len_bytes_t len_bytes;
    logic       is_load;
  } vls_addr_t;

endpackage
